/* fetch_frontend.f */
fetch_pkg.sv
pc_gen.sv
fetch_buffer.sv
bht.sv
branch_predict.sv
instr_queue.sv
fetch_frontend.sv
tb_fetch_mem.sv
tb_fetch_frontend.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_fetch_frontend \
		-f fetch_frontend.f --Mdir obj_dir -o sim_fetch_frontend
	./obj_dir/sim_fetch_frontend

clean:
	rm -rf obj_dir

/* tb_fetch_frontend.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_frontend;
  import fetch_pkg::*;

  localparam int unsigned PROG_WORDS  = 64;
  localparam int unsigned NUM_ROWS    = 9;
  localparam int unsigned CYCLE_LIMIT = NUM_ROWS * 40;
  localparam int unsigned HOLD_CYCLES = 16;

  // one row of stimulus
  typedef struct packed {
    logic [7:0] n;
    logic       hold;
    logic       redir;
    logic       misp;
    logic       res;
    addr_t      res_pc;
    logic       res_taken;
    addr_t      target;
  } row_t;

  logic      clk_i, rst_ni;
  logic      mem_req, mem_gnt, mem_rvalid;
  addr_t     mem_addr;
  fetch_id_t mem_id, mem_rid;
  instr_t    mem_rdata;
  logic      redirect_i, resolve_valid_i, resolve_is_branch_i;
  logic      resolve_taken_i, resolve_mispredict_i, credit_return_i;
  addr_t     redirect_pc_i, resolve_pc_i, resolve_target_i;
  logic      entry_valid_o, entry_taken_o;
  addr_t     entry_pc_o;
  instr_t    entry_instr_o;

  // program and its control flow view for the reference model
  instr_t     prog_word [PROG_WORDS];
  cf_e        prog_kind [PROG_WORDS];
  int         prog_off [PROG_WORDS];
  logic       ref_valid [BHT_ENTRIES];
  logic [1:0] ref_cnt [BHT_ENTRIES];
  row_t       rows [NUM_ROWS];
  addr_t      exp_pc;
  int         seen, owed, cycles;
  logic       withhold;

  fetch_frontend fetch_frontend_inst (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .mem_req_o(mem_req), .mem_addr_o(mem_addr), .mem_id_o(mem_id),
    .mem_gnt_i(mem_gnt), .mem_rvalid_i(mem_rvalid), .mem_rid_i(mem_rid),
    .mem_rdata_i(mem_rdata),
    .redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i),
    .resolve_valid_i(resolve_valid_i), .resolve_pc_i(resolve_pc_i),
    .resolve_is_branch_i(resolve_is_branch_i), .resolve_taken_i(resolve_taken_i),
    .resolve_mispredict_i(resolve_mispredict_i), .resolve_target_i(resolve_target_i),
    .entry_valid_o(entry_valid_o), .entry_pc_o(entry_pc_o),
    .entry_instr_o(entry_instr_o), .entry_taken_o(entry_taken_o),
    .credit_return_i(credit_return_i)
  );

  tb_fetch_mem #(.WORDS(PROG_WORDS)) tb_fetch_mem_inst (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_i(mem_req), .addr_i(mem_addr), .id_i(mem_id),
    .gnt_o(mem_gnt), .rvalid_o(mem_rvalid), .rid_o(mem_rid), .rdata_o(mem_rdata),
    .prog_i(prog_word)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // --------------------
  // program building
  // --------------------
  function automatic instr_t enc_jal(input int off);
    logic [20:0] o;
    o = off[20:0];
    return {o[20], o[10:1], o[11], o[19:12], 5'd1, OPC_JAL};
  endfunction

  function automatic instr_t enc_branch(input int off);
    logic [12:0] o;
    o = off[12:0];
    return {o[12], o[10:5], 5'd2, 5'd1, 3'b001, o[4:1], o[11], OPC_BRANCH};
  endfunction

  task automatic place(input addr_t a, input cf_e k, input int off);
    int idx;
    idx            = int'((a - BOOT_ADDR) >> 2);
    prog_kind[idx] = k;
    prog_off[idx]  = off;
    prog_word[idx] = (k == CF_JUMP) ? enc_jal(off) : enc_branch(off);
  endtask

  // --------------------
  // failure reporting
  // --------------------
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_addr(input string what, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic check_instr(input string what, input instr_t got, input instr_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "instruction mismatch");
    end
  endtask

  task automatic check_taken(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "taken bit mismatch");
    end
  endtask

  // --------------------
  // reference model
  // --------------------
  // two-bit counters seeded weak on the first outcome
  task automatic train(input addr_t pc, input logic taken);
    logic [3:0] b;
    b = pc[5:2];
    if (!ref_valid[b]) begin
      ref_cnt[b] = taken ? 2'd2 : 2'd1;
    end else if (taken && ref_cnt[b] != 2'd3) begin
      ref_cnt[b] = ref_cnt[b] + 2'd1;
    end else if (!taken && ref_cnt[b] != 2'd0) begin
      ref_cnt[b] = ref_cnt[b] - 2'd1;
    end
    ref_valid[b] = 1'b1;
  endtask

  task automatic next_expected(output addr_t pc, output instr_t w, output logic t);
    int idx;
    logic [3:0] b;
    pc  = exp_pc;
    idx = int'((pc - BOOT_ADDR) >> 2);
    b   = pc[5:2];
    w   = '0;
    t   = 1'b0;
    if (pc < BOOT_ADDR || idx >= PROG_WORDS) begin
      stop_run("reference model walked out of the program window");
    end else begin
      w = prog_word[idx];
      case (prog_kind[idx])
        CF_JUMP:   t = 1'b1;
        CF_BRANCH: t = ref_valid[b] ? ref_cnt[b][1] : (prog_off[idx] < 0);
        default:   t = 1'b0;
      endcase
      exp_pc = t ? pc + addr_t'(prog_off[idx]) : pc + 32'd4;
    end
  endtask

  // --------------------
  // per cycle driving
  // --------------------
  task automatic drive_credit();
    credit_return_i = (owed > 0) && !withhold;
    if (credit_return_i) begin
      owed--;
    end
  endtask

  // outputs are read 1 ns after the falling edge
  task automatic take_entry();
    addr_t  pc;
    instr_t w;
    logic   t;
    if (entry_valid_o) begin
      next_expected(pc, w, t);
      check_addr("entry pc", entry_pc_o, pc);
      check_instr("entry word", entry_instr_o, w);
      check_taken("entry taken", entry_taken_o, t);
      seen++;
      owed++;
    end
  endtask

  task automatic idle_cycle();
    @(negedge clk_i);
    redirect_i           = 1'b0;
    resolve_valid_i      = 1'b0;
    resolve_is_branch_i  = 1'b0;
    resolve_mispredict_i = 1'b0;
    drive_credit();
    #1;
    take_entry();
  endtask

  task automatic event_cycle(input row_t row);
    @(negedge clk_i);
    redirect_i           = row.redir;
    redirect_pc_i        = row.target;
    resolve_valid_i      = row.res | row.misp;
    resolve_pc_i         = row.res_pc;
    resolve_is_branch_i  = row.res;
    resolve_taken_i      = row.res_taken;
    resolve_mispredict_i = row.misp;
    resolve_target_i     = row.target;
    drive_credit();
    #1;
    if (entry_valid_o) begin
      stop_run("an entry was sent in a redirect cycle");
    end
    if (row.res) begin
      train(row.res_pc, row.res_taken);
    end
    exp_pc = row.target;
  endtask

  // run length guard
  always @(posedge clk_i) begin
    if (rst_ni) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
        stop_run("timeout, the entry stream did not finish in time");
      end
    end
  end

  initial begin
    int   goal, avail, start;
    row_t row;
    rst_ni               = 1'b0;
    redirect_i           = 1'b0;
    redirect_pc_i        = '0;
    resolve_valid_i      = 1'b0;
    resolve_pc_i         = '0;
    resolve_is_branch_i  = 1'b0;
    resolve_taken_i      = 1'b0;
    resolve_mispredict_i = 1'b0;
    resolve_target_i     = '0;
    credit_return_i      = 1'b0;
    withhold             = 1'b0;
    seen                 = 0;
    owed                 = 0;
    cycles               = 0;
    exp_pc               = BOOT_ADDR;
    for (int i = 0; i < BHT_ENTRIES; i++) begin
      ref_valid[i] = 1'b0;
      ref_cnt[i]   = 2'd0;
    end
    // plain alu words carry their own address
    for (int i = 0; i < PROG_WORDS; i++) begin
      addr_t a;
      a            = BOOT_ADDR + addr_t'(4 * i);
      prog_word[i] = {a[24:0] ^ a[31:7], 7'b001_0011};
      prog_kind[i] = CF_NONE;
      prog_off[i]  = 0;
    end
    place(32'h1010, CF_JUMP, 32);
    place(32'h1038, CF_BRANCH, 16);
    place(32'h1048, CF_BRANCH, -20);
    place(32'h1060, CF_JUMP, -96);
    place(32'h108C, CF_JUMP, -92);
    // n, hold, redirect, mispredict, resolve, resolve pc, taken, target
    rows[0] = '{8'd12, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0};
    rows[1] = '{8'd3, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0};
    rows[2] = '{8'd5, 1'b0, 1'b1, 1'b0, 1'b1, 32'h1038, 1'b1, 32'h1030};
    rows[3] = '{8'd4, 1'b0, 1'b1, 1'b0, 1'b1, 32'h1038, 1'b1, 32'h1030};
    rows[4] = '{8'd8, 1'b0, 1'b0, 1'b1, 1'b1, 32'h1048, 1'b0, 32'h104C};
    rows[5] = '{8'd16, 1'b0, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0, 32'h1080};
    rows[6] = '{8'd10, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0};
    rows[7] = '{8'd6, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0};
    rows[8] = '{8'd12, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0};

    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;

    for (int r = 0; r < NUM_ROWS; r++) begin
      row  = rows[r];
      goal = seen + int'(row.n);
      while (seen < goal) begin
        idle_cycle();
      end
      // decode stops returning credits for a while
      if (row.hold) begin
        withhold = 1'b1;
        avail    = int'(DECODE_CREDITS) - owed;
        start    = seen;
        repeat (HOLD_CYCLES) idle_cycle();
        if (seen - start > avail) begin
          stop_run("more entries were sent than decode had credits for");
        end
        withhold = 1'b0;
      end
      if (row.redir || row.misp) begin
        event_cycle(row);
      end
    end
    repeat (2) idle_cycle();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* tb_fetch_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_mem #(
  parameter int unsigned WORDS = 64
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  fetch_pkg::addr_t     addr_i,
  input  fetch_pkg::fetch_id_t id_i,
  output logic                 gnt_o,
  output logic                 rvalid_o,
  output fetch_pkg::fetch_id_t rid_o,
  output fetch_pkg::instr_t    rdata_o,
  input  fetch_pkg::instr_t    prog_i [WORDS]
);
  import fetch_pkg::*;

  logic [31:0] rng;
  int unsigned cyc;
  // granted requests waiting for their answer, oldest first
  fetch_id_t   pend_id [$];
  instr_t      pend_data [$];
  int unsigned pend_due [$];

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // program window at the boot address, address pattern elsewhere
  function automatic instr_t read_word(input addr_t a);
    addr_t idx;
    idx = (a - BOOT_ADDR) >> 2;
    if (a >= BOOT_ADDR && idx < WORDS) begin
      return prog_i[idx];
    end
    return {a[24:0] ~^ a[31:7], 7'b001_0011};
  endfunction

  // --------------------
  // grant and response
  // --------------------
  // everything moves on the falling edge, req is stable by then
  initial begin
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rid_o    = '0;
    rdata_o  = '0;
    rng      = 32'd94019;
    cyc      = 0;
    forever begin
      @(negedge clk_i);
      if (!rst_ni) begin
        gnt_o    = 1'b0;
        rvalid_o = 1'b0;
        pend_id.delete();
        pend_data.delete();
        pend_due.delete();
      end else begin
        cyc++;
        rvalid_o = 1'b0;
        // at most one answer per cycle, in grant order
        if (pend_due.size() != 0 && pend_due[0] <= cyc) begin
          rvalid_o = 1'b1;
          rid_o    = pend_id.pop_front();
          rdata_o  = pend_data.pop_front();
          void'(pend_due.pop_front());
        end
        rng   = xorshift(rng);
        gnt_o = (rng[1:0] != 2'b00);
        // transfer happens at the coming rising edge
        if (req_i && gnt_o) begin
          pend_id.push_back(id_i);
          pend_data.push_back(read_word(addr_i));
          pend_due.push_back(cyc + 1 + (rng[3:2] % 3));
        end
      end
    end
  end

endmodule

`default_nettype wire

/* fetch_frontend.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // instruction memory
  output logic                 mem_req_o,
  output fetch_pkg::addr_t     mem_addr_o,
  output fetch_pkg::fetch_id_t mem_id_o,
  input  logic                 mem_gnt_i,
  input  logic                 mem_rvalid_i,
  input  fetch_pkg::fetch_id_t mem_rid_i,
  input  fetch_pkg::instr_t    mem_rdata_i,
  // backend
  input  logic                 redirect_i,
  input  fetch_pkg::addr_t     redirect_pc_i,
  input  logic                 resolve_valid_i,
  input  fetch_pkg::addr_t     resolve_pc_i,
  input  logic                 resolve_is_branch_i,
  input  logic                 resolve_taken_i,
  input  logic                 resolve_mispredict_i,
  input  fetch_pkg::addr_t     resolve_target_i,
  // decode
  output logic                 entry_valid_o,
  output fetch_pkg::addr_t     entry_pc_o,
  output fetch_pkg::instr_t    entry_instr_o,
  output logic                 entry_taken_o,
  input  logic                 credit_return_i
);
  import fetch_pkg::*;

  logic       grant, issue_ok, resp_keep;
  fetch_id_t  free_id;
  addr_t      resp_pc;
  logic       fetch_valid;
  addr_t      fetch_pc;
  instr_t     fetch_instr;
  logic       predict_taken;
  addr_t      predict_target;
  queue_cnt_t queue_cnt;
  logic       mispredict, flush, kill;

  // --------------------
  // kill and flush
  // --------------------
  assign mispredict = resolve_valid_i & resolve_mispredict_i;
  // backend events empty the whole pipe
  assign flush      = redirect_i | mispredict;
  // a prediction only kills what is still in flight
  assign kill       = flush | predict_taken;

  pc_gen pc_gen_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .issue_ok_i          (issue_ok),
    .mem_gnt_i           (mem_gnt_i),
    .free_id_i           (free_id),
    .redirect_i          (redirect_i),
    .redirect_pc_i       (redirect_pc_i),
    .resolve_mispredict_i(mispredict),
    .resolve_target_i    (resolve_target_i),
    .predict_taken_i     (predict_taken),
    .predict_target_i    (predict_target),
    .mem_req_o           (mem_req_o),
    .mem_addr_o          (mem_addr_o),
    .mem_id_o            (mem_id_o),
    .grant_o             (grant)
  );

  fetch_buffer fetch_buffer_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .grant_i          (grant),
    .req_addr_i       (mem_addr_o),
    .kill_i           (kill),
    .mem_rvalid_i     (mem_rvalid_i),
    .mem_rid_i        (mem_rid_i),
    .queue_cnt_i      (queue_cnt),
    .fetch_reg_valid_i(fetch_valid),
    .free_id_o        (free_id),
    .issue_ok_o       (issue_ok),
    .resp_keep_o      (resp_keep),
    .resp_pc_o        (resp_pc)
  );

  branch_predict branch_predict_inst (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .resp_keep_i        (resp_keep),
    .mem_rdata_i        (mem_rdata_i),
    .resp_pc_i          (resp_pc),
    .flush_i            (flush),
    .resolve_valid_i    (resolve_valid_i),
    .resolve_pc_i       (resolve_pc_i),
    .resolve_is_branch_i(resolve_is_branch_i),
    .resolve_taken_i    (resolve_taken_i),
    .fetch_valid_o      (fetch_valid),
    .fetch_pc_o         (fetch_pc),
    .fetch_instr_o      (fetch_instr),
    .predict_taken_o    (predict_taken),
    .predict_target_o   (predict_target)
  );

  // the predicted entry itself goes into the queue with its taken bit
  instr_queue instr_queue_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (fetch_valid),
    .push_pc_i      (fetch_pc),
    .push_instr_i   (fetch_instr),
    .push_taken_i   (predict_taken),
    .flush_i        (flush),
    .credit_return_i(credit_return_i),
    .queue_cnt_o    (queue_cnt),
    .entry_valid_o  (entry_valid_o),
    .entry_pc_o     (entry_pc_o),
    .entry_instr_o  (entry_instr_o),
    .entry_taken_o  (entry_taken_o)
  );

endmodule

`default_nettype wire

/* instr_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_queue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push_i,
  input  fetch_pkg::addr_t      push_pc_i,
  input  fetch_pkg::instr_t     push_instr_i,
  input  logic                  push_taken_i,
  input  logic                  flush_i,
  input  logic                  credit_return_i,
  output fetch_pkg::queue_cnt_t queue_cnt_o,
  output logic                  entry_valid_o,
  output fetch_pkg::addr_t      entry_pc_o,
  output fetch_pkg::instr_t     entry_instr_o,
  output logic                  entry_taken_o
);
  import fetch_pkg::*;

  // storage
  addr_t                          pc_q [QUEUE_DEPTH];
  instr_t                         instr_q [QUEUE_DEPTH];
  logic [QUEUE_DEPTH-1:0]         taken_q;
  // pointers wrap on their own
  logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr_q, rd_ptr_q;
  queue_cnt_t                     cnt_q;
  // decode side slots still free
  credit_cnt_t                    credit_q;
  logic                           pop;
  logic                           wr_en;

  assign wr_en = push_i & ~flush_i;

  // --------------------
  // decode side
  // --------------------
  // send the head whenever decode has room and no flush is active
  assign entry_valid_o = (cnt_q != '0) && (credit_q != '0) && !flush_i;
  assign pop           = entry_valid_o;
  assign entry_pc_o    = pc_q[rd_ptr_q];
  assign entry_instr_o = instr_q[rd_ptr_q];
  assign entry_taken_o = taken_q[rd_ptr_q];
  assign queue_cnt_o   = cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      credit_q <= credit_cnt_t'(DECODE_CREDITS);
    end else begin
      // a flush leaves the decode credits alone
      credit_q <= credit_q - credit_cnt_t'(pop) + credit_cnt_t'(credit_return_i);
      if (flush_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
      end else begin
        if (push_i) begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
        cnt_q <= cnt_q + queue_cnt_t'(push_i) - queue_cnt_t'(pop);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      pc_q[wr_ptr_q]    <= push_pc_i;
      instr_q[wr_ptr_q] <= push_instr_i;
      taken_q[wr_ptr_q] <= push_taken_i;
    end
  end

  // the issue check in the fetch buffer reserves a slot for every push
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_en |-> cnt_q != queue_cnt_t'(QUEUE_DEPTH))
    else $error("push into a full instruction queue");

  // decode never returns more than it was given
  a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= credit_cnt_t'(DECODE_CREDITS))
    else $error("credit count above decode capacity");

endmodule

`default_nettype wire

/* branch_predict.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_predict (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              resp_keep_i,
  input  fetch_pkg::instr_t mem_rdata_i,
  input  fetch_pkg::addr_t  resp_pc_i,
  input  logic              flush_i,
  input  logic              resolve_valid_i,
  input  fetch_pkg::addr_t  resolve_pc_i,
  input  logic              resolve_is_branch_i,
  input  logic              resolve_taken_i,
  output logic              fetch_valid_o,
  output fetch_pkg::addr_t  fetch_pc_o,
  output fetch_pkg::instr_t fetch_instr_o,
  output logic              predict_taken_o,
  output fetch_pkg::addr_t  predict_target_o
);
  import fetch_pkg::*;

  // fetch register
  logic   valid_q;
  addr_t  pc_q;
  instr_t instr_q;
  // predecode
  cf_e    cf;
  addr_t  imm_j, imm_b;
  logic   bht_valid, bht_taken;
  logic   taken;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= resp_keep_i & ~flush_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (resp_keep_i) begin
      pc_q    <= resp_pc_i;
      instr_q <= mem_rdata_i;
    end
  end

  // --------------------
  // predecode
  // --------------------
  always_comb begin
    unique case (instr_q[6:0])
      OPC_JAL:    cf = CF_JUMP;
      OPC_BRANCH: cf = CF_BRANCH;
      default:    cf = CF_NONE;
    endcase
  end

  // sign extended j and b immediates
  assign imm_j = {{12{instr_q[31]}}, instr_q[19:12], instr_q[20], instr_q[30:21], 1'b0};
  assign imm_b = {{20{instr_q[31]}}, instr_q[7], instr_q[30:25], instr_q[11:8], 1'b0};

  // jal always taken, branch by bht or backward rule
  always_comb begin
    unique case (cf)
      CF_JUMP:   taken = 1'b1;
      CF_BRANCH: taken = bht_valid ? bht_taken : imm_b[31];
      default:   taken = 1'b0;
    endcase
  end

  assign predict_taken_o  = valid_q & taken;
  assign predict_target_o = pc_q + ((cf == CF_JUMP) ? imm_j : imm_b);

  assign fetch_valid_o = valid_q;
  assign fetch_pc_o    = pc_q;
  assign fetch_instr_o = instr_q;

  // resolved conditional branches train the table
  bht bht_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_pc_i   (pc_q),
    .update_valid_i(resolve_valid_i & resolve_is_branch_i),
    .update_pc_i   (resolve_pc_i),
    .update_taken_i(resolve_taken_i),
    .pred_valid_o  (bht_valid),
    .pred_taken_o  (bht_taken)
  );

endmodule

`default_nettype wire

/* bht.sv */
`timescale 1ns/10ps
`default_nettype none

module bht (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  fetch_pkg::addr_t lookup_pc_i,
  input  logic             update_valid_i,
  input  fetch_pkg::addr_t update_pc_i,
  input  logic             update_taken_i,
  output logic             pred_valid_o,
  output logic             pred_taken_o
);
  import fetch_pkg::*;

  // an entry is valid once it has seen one resolve
  logic [BHT_ENTRIES-1:0] valid_q;
  // two-bit saturating counters, msb is the prediction
  logic [1:0]             cnt_q [BHT_ENTRIES];
  bht_idx_t               lookup_idx;
  bht_idx_t               update_idx;

  // word address bits, no tag
  assign lookup_idx = lookup_pc_i[5:2];
  assign update_idx = update_pc_i[5:2];

  // --------------------
  // lookup
  // --------------------
  assign pred_valid_o = valid_q[lookup_idx];
  assign pred_taken_o = cnt_q[lookup_idx][1];

  // --------------------
  // update
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (update_valid_i) begin
      valid_q[update_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (update_valid_i) begin
      if (!valid_q[update_idx]) begin
        // first outcome seeds a weak counter
        cnt_q[update_idx] <= update_taken_i ? 2'b10 : 2'b01;
      end else if (update_taken_i && cnt_q[update_idx] != 2'b11) begin
        cnt_q[update_idx] <= cnt_q[update_idx] + 2'b01;
      end else if (!update_taken_i && cnt_q[update_idx] != 2'b00) begin
        cnt_q[update_idx] <= cnt_q[update_idx] - 2'b01;
      end
    end
  end

endmodule

`default_nettype wire

/* fetch_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_buffer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  grant_i,
  input  fetch_pkg::addr_t      req_addr_i,
  input  logic                  kill_i,
  input  logic                  mem_rvalid_i,
  input  fetch_pkg::fetch_id_t  mem_rid_i,
  input  fetch_pkg::queue_cnt_t queue_cnt_i,
  input  logic                  fetch_reg_valid_i,
  output fetch_pkg::fetch_id_t  free_id_o,
  output logic                  issue_ok_o,
  output logic                  resp_keep_o,
  output fetch_pkg::addr_t      resp_pc_o
);
  import fetch_pkg::*;

  // per slot state
  logic [NR_FETCH_IDS-1:0] valid_d, valid_q;
  logic [NR_FETCH_IDS-1:0] flushed_d, flushed_q;
  // pc of each request, handed back with its response
  addr_t                   pc_q [NR_FETCH_IDS];
  logic                    has_free;
  // queue entries plus live requests plus the fetch register
  logic [3:0]              in_use;

  // --------------------
  // slot allocation
  // --------------------
  // scan downward so the lowest free slot wins
  always_comb begin
    free_id_o = '0;
    has_free  = 1'b0;
    for (int i = NR_FETCH_IDS - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_id_o = fetch_id_t'(i);
        has_free  = 1'b1;
      end
    end
  end

  // flushed requests never reach the queue so they take no space
  always_comb begin
    in_use = 4'(queue_cnt_i) + 4'(fetch_reg_valid_i);
    for (int i = 0; i < NR_FETCH_IDS; i++) begin
      in_use = in_use + 4'(valid_q[i] & ~flushed_q[i]);
    end
  end

  assign issue_ok_o = has_free && (in_use < 4'(QUEUE_DEPTH));

  // --------------------
  // responses
  // --------------------
  assign resp_pc_o   = pc_q[mem_rid_i];
  // a kill in the same cycle drops the word too
  assign resp_keep_o = mem_rvalid_i && valid_q[mem_rid_i] && !flushed_q[mem_rid_i] && !kill_i;

  always_comb begin
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // everything in flight belongs to the old path
    if (kill_i) begin
      flushed_d = flushed_q | valid_q;
    end
    if (mem_rvalid_i) begin
      valid_d[mem_rid_i] = 1'b0;
    end
    if (grant_i) begin
      valid_d[free_id_o]   = 1'b1;
      // a grant in a kill cycle still fetches from the old path
      flushed_d[free_id_o] = kill_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant_i) begin
      pc_q[free_id_o] <= req_addr_i;
    end
  end

  // memory only answers ids that were granted and are still open
  a_rid_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rvalid_i |-> valid_q[mem_rid_i])
    else $error("response for an idle fetch slot");

endmodule

`default_nettype wire

/* pc_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module pc_gen (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 issue_ok_i,
  input  logic                 mem_gnt_i,
  input  fetch_pkg::fetch_id_t free_id_i,
  input  logic                 redirect_i,
  input  fetch_pkg::addr_t     redirect_pc_i,
  input  logic                 resolve_mispredict_i,
  input  fetch_pkg::addr_t     resolve_target_i,
  input  logic                 predict_taken_i,
  input  fetch_pkg::addr_t     predict_target_i,
  output logic                 mem_req_o,
  output fetch_pkg::addr_t     mem_addr_o,
  output fetch_pkg::fetch_id_t mem_id_o,
  output logic                 grant_o
);
  import fetch_pkg::*;

  // low until the boot address is loaded
  logic  run_q;
  addr_t npc_d, npc_q;
  // any change of the fetch stream
  logic  kill;

  assign kill = redirect_i | resolve_mispredict_i | predict_taken_i;

  // --------------------
  // memory request
  // --------------------
  // one aligned word per request
  assign mem_req_o  = run_q & issue_ok_i;
  assign mem_addr_o = {npc_q[31:2], 2'b00};
  // slot id comes straight from the fetch buffer
  assign mem_id_o   = free_id_i;
  assign grant_o    = mem_req_o & mem_gnt_i;

  // --------------------
  // next pc
  // --------------------
  // backend first, then the predictor, then sequential fetch
  always_comb begin
    npc_d = npc_q;
    if (redirect_i) begin
      npc_d = redirect_pc_i;
    end else if (resolve_mispredict_i) begin
      npc_d = resolve_target_i;
    end else if (predict_taken_i) begin
      npc_d = predict_target_i;
    end else if (!run_q) begin
      // first cycle out of reset
      npc_d = BOOT_ADDR;
    end else if (grant_o) begin
      npc_d = npc_q + 32'd4;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q <= 1'b0;
      npc_q <= '0;
    end else begin
      run_q <= 1'b1;
      npc_q <= npc_d;
    end
  end

  // a waiting request stays up with its address until it is granted or killed
  a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_gnt_i && !kill |=> mem_req_o && $stable(mem_addr_o))
    else $error("fetch request dropped or moved before grant");

endmodule

`default_nettype wire

/* fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  // --------------------
  // widths
  // --------------------
  // instruction address and instruction word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;

  // --------------------
  // sizes
  // --------------------
  // outstanding memory requests, one per id
  localparam int unsigned NR_FETCH_IDS = 4;
  typedef logic [$clog2(NR_FETCH_IDS)-1:0] fetch_id_t;

  // branch history table indexed by pc[5:2]
  localparam int unsigned BHT_ENTRIES = 16;
  typedef logic [$clog2(BHT_ENTRIES)-1:0] bht_idx_t;

  // instruction queue toward decode
  localparam int unsigned QUEUE_DEPTH = 4;
  typedef logic [$clog2(QUEUE_DEPTH):0] queue_cnt_t;

  // buffer slots on the decode side
  localparam int unsigned DECODE_CREDITS = 4;
  typedef logic [$clog2(DECODE_CREDITS):0] credit_cnt_t;

  // first fetch after reset
  localparam addr_t BOOT_ADDR = 32'h0000_1000;

  // --------------------
  // predecode
  // --------------------
  // major opcodes of interest
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;

  // control flow class of a fetched word
  typedef enum logic [1:0] {
    CF_NONE,
    CF_BRANCH,
    CF_JUMP
  } cf_e;

endpackage

`default_nettype wire
